/* all.f */
+incdir+rtl
rtl/lc3b_pkg.sv
rtl/mem_arbiter.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/exec_stage.sv
rtl/memory_stage.sv
rtl/lc3b_pipeline.sv
sim/tb_clock_gen.sv
sim/tb_lc3b_pipeline.sv

/* sim/lc3b_stim.txt */
# M <address> <word>: memory image in hex, program from 0000, load data at 00a0
# S <address> <data>: expected store in hex, in program order
M 0000 5020   # and r0, r0, #0
M 0002 1225   # add r1, r0, #5
M 0004 147d   # add r2, r1, #-3
M 0006 1642   # add r3, r1, r2
M 0008 58e6   # and r4, r3, #6
M 000a 9b3f   # not r5, r4
M 000c 5d43   # and r6, r5, r3
M 000e ee38   # lea r7, #56 -> 0080
M 0010 77c0   # str r3, r7, #0
M 0012 75c1   # str r2, r7, #1
M 0014 79c2   # str r4, r7, #2
M 0016 7bc3   # str r5, r7, #3
M 0018 7dc4   # str r6, r7, #4
M 001a 7fc5   # str r7, r7, #5
M 001c 1241   # add r1, r1, r1
M 001e 73c6   # str r1, r7, #6
M 0020 1446   # add r2, r1, r6
M 0022 94bf   # not r2, r2
M 0024 75c7   # str r2, r7, #7
M 0026 67d0   # ldr r3, r7, #16
M 0028 18e1   # add r4, r3, #1 right after the load
M 002a 79c8   # str r4, r7, #8
M 002c 6bd1   # ldr r5, r7, #17
M 002e 7bc9   # str r5, r7, #9 right after the load
M 0030 0601   # brzp, not taken
M 0032 71ca   # str r0, r7, #10
M 0034 0803   # brn to 003c, taken
M 0036 73cb   # skipped
M 0038 75cc   # skipped
M 003a 77cd   # skipped
M 003c 1c20   # add r6, r0, #0
M 003e 0a02   # brnp, not taken
M 0040 73ce   # str r1, r7, #14
M 0042 0401   # brz to 0046, taken
M 0044 75cf   # skipped
M 0046 1275   # add r1, r1, #-11
M 0048 0201   # brp, not taken
M 004a 73d4   # str r1, r7, #20
M 004c 0e01   # brnzp to 0050, taken
M 004e 71d5   # skipped
M 0050 77d3   # str r3, r7, #19
M 0052 0fff   # brnzp to self
M 00a0 1234
M 00a2 8001
S 0080 0007
S 0082 0002
S 0084 0006
S 0086 fff9
S 0088 0001
S 008a 0080
S 008c 000a
S 008e fff4
S 0090 1235
S 0092 8001
S 0094 0000
S 009c 000a
S 00a8 ffff
S 00a6 1234

/* sim/tb_lc3b_pipeline.sv */
`timescale 1ns/100ps

module tb_lc3b_pipeline;

    localparam int period_ns    = 10;
    localparam int reset_cycles = 16;
    localparam int max_delay    = 5;        // memory answers in 1 to 5 cycles
    localparam int drain_cycles = 100;      // time to catch stores past the end

    typedef struct packed {
        logic [15:0] address;
        logic [15:0] data;
    } store_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [15:0] address;
        logic [15:0] wdata;
    } port_req_t;

    logic        clk;
    logic        rst_n;
    logic [15:0] mem_rdata;
    logic        mem_resp;
    logic        mem_read;
    logic        mem_write;
    logic [15:0] mem_address;
    logic [15:0] mem_wdata;

    logic [15:0] mem [0:32767];             // word indexed
    store_t      expected [$];
    int          image_words;
    int          stores_seen;
    int          pass_count;
    int          fail_count;
    bit          loaded;

    tb_clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) tb_clock_gen_i (
        .clk, .rst_n
    );

    lc3b_pipeline lc3b_pipeline_i (
        .clk, .rst_n, .mem_rdata, .mem_resp,
        .mem_read, .mem_write, .mem_address, .mem_wdata
    );

    function automatic port_req_t sample_port();
        port_req_t p;
        p.read    = mem_read;
        p.write   = mem_write;
        p.address = mem_address;
        p.wdata   = mem_wdata;
        return p;
    endfunction

    task automatic load_stimulus(output bit ok);
        int               fd;
        int               fields;
        logic [8*128-1:0] line;
        logic [7:0]       tag;
        logic [15:0]      addr;
        logic [15:0]      value;
        store_t           entry;
        ok = 1'b0;
        for (int i = 0; i < 32768; i++)
            mem[i] = 16'(i) ^ 16'ha5a5;
        fd = $fopen("sim/lc3b_stim.txt", "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                fields = $sscanf(line, "%s %h %h", tag, addr, value);
                if (fields == 3 && tag == "M")
                begin
                    mem[addr[15:1]] = value;
                    image_words++;
                end
                else if (fields == 3 && tag == "S")
                begin
                    entry.address = addr;
                    entry.data    = value;
                    expected.push_back(entry);
                end
            end
            $fclose(fd);
            ok = (image_words > 0) && (expected.size() > 0);
        end
    endtask

    task automatic check_first_request(input port_req_t req);
        if (!req.read || req.write || req.address != 16'h0000)
        begin
            $display("FAILED %0t: first request read=%b write=%b at %h, expected a read at 0000",
                     $time, req.read, req.write, req.address);
            fail_count++;
        end
        else
        begin
            $display("reset fetch: first read at 0000 ok");
            pass_count++;
        end
    endtask

    task automatic check_store(input port_req_t req);
        store_t want;
        if (stores_seen >= expected.size())
        begin
            $display("at %0t the DUT stored %h to %h after the last expected store",
                     $time, req.wdata, req.address);
            fail_count++;
        end
        else
        begin
            want = expected[stores_seen];
            if (req.address != want.address || req.wdata != want.data)
            begin
                $display("FAILED %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                         stores_seen, req.wdata, req.address, want.data, want.address);
                fail_count++;
            end
            else
            begin
                $display("store %0d: %h to %h ok", stores_seen, req.wdata, req.address);
                pass_count++;
            end
        end
        stores_seen++;
    endtask

    // answer one access with a single cycle resp pulse
    task automatic respond(input port_req_t req);
        if (req.write)
        begin
            mem[req.address[15:1]] = req.wdata;
            check_store(req);
        end
        else
            mem_rdata = mem[req.address[15:1]];
        mem_resp = 1'b1;
    endtask

    initial
    begin : memory_model
        int        seed_ret;
        int        wait_left;
        bit        busy;
        bit        first_seen;
        port_req_t cur;
        port_req_t held;
        seed_ret   = $urandom(32'hc9c2_480f);
        mem_resp   = 1'b0;
        mem_rdata  = '0;
        busy       = 1'b0;
        first_seen = 1'b0;
        wait_left  = 0;
        @(posedge rst_n);
        forever
        begin
            @(posedge clk);
            #1;
            cur = sample_port();
            if (mem_resp)
            begin
                mem_resp = 1'b0;        // DUT took it at this edge
                busy     = 1'b0;
            end
            if ($isunknown({cur.read, cur.write}) ||
                ((cur.read || cur.write) && $isunknown(cur.address)) ||
                (cur.write && $isunknown(cur.wdata)))
            begin
                $display("at %0t the memory port shows an unknown request", $time);
                fail_count++;
            end
            if (!first_seen)
                check_first_request(cur);
            first_seen = 1'b1;
            if (!busy && (cur.read || cur.write))
            begin
                busy      = 1'b1;
                held      = cur;
                wait_left = int'($urandom % max_delay) + 1;
            end
            else if (busy)
            begin
                if (cur !== held)
                begin
                    $display("at %0t the memory request changed before its response", $time);
                    fail_count++;
                end
                wait_left--;
                if (wait_left == 0)
                    respond(held);
            end
        end
    end

    initial
    begin : watchdog
        wait (loaded);
        #(reset_cycles * period_ns + image_words * 4 * 6 * period_ns);
        $display("timeout: %0d of %0d expected stores seen before the time limit",
                 stores_seen, expected.size());
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        bit ok;
        image_words = 0;
        stores_seen = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_stimulus(ok);
        if (!ok)
        begin
            $display("could not read a program and expected stores from sim/lc3b_stim.txt");
            $display("TB FAILED");
            $finish;
        end
        else
        begin
            $display("loaded %0d image words and %0d expected stores",
                     image_words, expected.size());
            loaded = 1'b1;
            wait (stores_seen >= expected.size());
            repeat (drain_cycles)
                @(posedge clk);
            if (stores_seen != expected.size())
            begin
                $display("store count: %0d stores seen, %0d expected",
                         stores_seen, expected.size());
                fail_count++;
            end
            else
            begin
                $display("store count: %0d of %0d ok", stores_seen, expected.size());
                pass_count++;
            end
            $display("checks: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0)
            begin
                $display("TB PASSED");
            end
            else
            begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles)
            @(posedge clk);
        #1;                 // same offset as the other inputs
        rst_n = 1'b1;
    end

endmodule

/* rtl/lc3b_pipeline.sv */
`timescale 1ns/100ps

module lc3b_pipeline (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3b_pkg::lc3b_word mem_rdata,
    input  logic               mem_resp,
    output logic               mem_read,
    output logic               mem_write,
    output lc3b_pkg::lc3b_word mem_address,
    output lc3b_pkg::lc3b_word mem_wdata
);

    lc3b_pkg::mem_req_t   fetch_req;
    lc3b_pkg::mem_req_t   data_req;
    lc3b_pkg::lc3b_word   fetch_word;
    lc3b_pkg::lc3b_word   data_rdata;
    logic                 advance;
    logic                 stall;
    logic                 redirect;
    lc3b_pkg::lc3b_word   branch_target;
    lc3b_pkg::lc3b_word   ir;
    lc3b_pkg::lc3b_word   pc_plus2;
    lc3b_pkg::ctrl_word_t id_ctrl;
    lc3b_pkg::ctrl_word_t ex_ctrl;
    lc3b_pkg::ctrl_word_t mem_ctrl;
    lc3b_pkg::id_ex_t     id_ex;
    lc3b_pkg::ex_mem_t    ex_mem;
    lc3b_pkg::mem_wb_t    mem_wb;
    lc3b_pkg::lc3b_word   mem_result;
    lc3b_pkg::fwd_sel_e   fwd_sel_a;
    lc3b_pkg::fwd_sel_e   fwd_sel_b;
    lc3b_pkg::fwd_sel_e   fwd_sel_st;

    mem_arbiter mem_arbiter_i (
        .clk, .rst_n, .fetch_req, .data_req, .mem_rdata, .mem_resp,
        .mem_read, .mem_write, .mem_address, .mem_wdata,
        .fetch_word, .data_rdata, .advance
    );

    fetch_unit fetch_unit_i (
        .clk, .rst_n, .advance, .stall, .redirect, .branch_target,
        .fetch_word, .fetch_req, .ir, .pc_plus2
    );

    decode_stage decode_stage_i (
        .clk, .rst_n, .advance, .stall, .redirect, .ir, .pc_plus2,
        .mem_wb, .id_ctrl, .id_ex
    );

    hazard_unit hazard_unit_i (
        .id_ctrl, .ex_ctrl, .mem_ctrl, .mem_wb,
        .fwd_sel_a, .fwd_sel_b, .fwd_sel_st, .stall
    );

    exec_stage exec_stage_i (
        .clk, .rst_n, .advance, .redirect, .id_ex,
        .fwd_sel_a, .fwd_sel_b, .fwd_sel_st,
        .mem_result,
        .wb_value (mem_wb.value),   // value in the writeback register
        .ex_ctrl, .ex_mem
    );

    memory_stage memory_stage_i (
        .clk, .rst_n, .advance, .ex_mem, .data_rdata, .data_req,
        .mem_ctrl, .mem_result, .redirect, .branch_target, .mem_wb
    );

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  lc3b_pkg::ex_mem_t    ex_mem,
    input  lc3b_pkg::lc3b_word   data_rdata,
    output lc3b_pkg::mem_req_t   data_req,
    output lc3b_pkg::ctrl_word_t mem_ctrl,
    output lc3b_pkg::lc3b_word   mem_result,
    output logic                 redirect,
    output lc3b_pkg::lc3b_word   branch_target,
    output lc3b_pkg::mem_wb_t    mem_wb
);
    import lc3b_pkg::*;

    lc3b_nzp  cc;
    lc3b_nzp  cc_next;
    lc3b_word wr_value;

    assign mem_ctrl = ex_mem.ctrl;

    always_comb
    begin
        data_req.read    = ex_mem.ctrl.mem_read;
        data_req.write   = ex_mem.ctrl.mem_write;
        data_req.address = ex_mem.address;
        data_req.wdata   = ex_mem.store_data;
    end

    // value known before the access for forwarding
    assign mem_result = (ex_mem.ctrl.opcode == op_lea) ? ex_mem.branch_target : ex_mem.result;
    assign wr_value   = ex_mem.ctrl.mem_read ? data_rdata : mem_result;

    always_comb
    begin
        if (wr_value[15])
            cc_next = 3'b100;
        else if (wr_value == '0)
            cc_next = 3'b010;
        else
            cc_next = 3'b001;
    end

    assign branch_target = ex_mem.branch_target;
    assign redirect      = !ex_mem.ctrl.is_nop && ex_mem.ctrl.opcode == op_br &&
                           |(cc & ex_mem.ctrl.nzp_mask);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cc     <= 3'b010;
            mem_wb <= '0;
        end
        else if (advance)
        begin
            if (ex_mem.ctrl.load_regfile)
                cc <= cc_next;
            mem_wb.load_regfile <= ex_mem.ctrl.load_regfile;
            mem_wb.dest         <= ex_mem.ctrl.dest;
            mem_wb.value        <= wr_value;
        end
    end

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic                 redirect,
    input  lc3b_pkg::id_ex_t     id_ex,
    input  lc3b_pkg::fwd_sel_e   fwd_sel_a,
    input  lc3b_pkg::fwd_sel_e   fwd_sel_b,
    input  lc3b_pkg::fwd_sel_e   fwd_sel_st,
    input  lc3b_pkg::lc3b_word   mem_result,
    input  lc3b_pkg::lc3b_word   wb_value,
    output lc3b_pkg::ctrl_word_t ex_ctrl,
    output lc3b_pkg::ex_mem_t    ex_mem
);
    import lc3b_pkg::*;

    lc3b_word op_a;
    lc3b_word op_b;
    lc3b_word op_st;
    lc3b_word alu_out;

    function automatic lc3b_word fwd_mux(input fwd_sel_e sel, input lc3b_word reg_val,
                                         input lc3b_word mem_val, input lc3b_word wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign ex_ctrl = id_ex.ctrl;
    assign op_a    = fwd_mux(fwd_sel_a, id_ex.src_a, mem_result, wb_value);
    assign op_b    = fwd_mux(fwd_sel_b, id_ex.src_b, mem_result, wb_value);
    assign op_st   = fwd_mux(fwd_sel_st, id_ex.store_data, mem_result, wb_value);

    always_comb
    begin
        case (id_ex.ctrl.aluop)
            alu_add: alu_out = op_a + op_b;
            alu_and: alu_out = op_a & op_b;
            alu_not: alu_out = ~op_a;
            default: alu_out = op_a;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_mem <= '{ctrl: nop_ctrl(), default: '0};
        else if (advance)
        begin
            ex_mem.ctrl          <= redirect ? nop_ctrl() : id_ex.ctrl;
            ex_mem.result        <= alu_out;
            ex_mem.address       <= op_a + id_ex.offset;       // base + offset6
            ex_mem.store_data    <= op_st;
            ex_mem.branch_target <= id_ex.pc_plus2 + id_ex.offset;
        end
    end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  lc3b_pkg::ctrl_word_t id_ctrl,
    input  lc3b_pkg::ctrl_word_t ex_ctrl,
    input  lc3b_pkg::ctrl_word_t mem_ctrl,
    input  lc3b_pkg::mem_wb_t    mem_wb,
    output lc3b_pkg::fwd_sel_e   fwd_sel_a,
    output lc3b_pkg::fwd_sel_e   fwd_sel_b,
    output lc3b_pkg::fwd_sel_e   fwd_sel_st,
    output logic                 stall
);
    import lc3b_pkg::*;

    function automatic logic reads_sr1(input ctrl_word_t c);
        return !c.is_nop && (c.opcode inside {op_add, op_and, op_not, op_ldr, op_str});
    endfunction

    function automatic logic reads_sr2(input ctrl_word_t c);
        return ((c.opcode inside {op_add, op_and}) && !c.imm_enable) || c.mem_write;
    endfunction

    // the younger memory stage wins unless it holds a load
    function automatic fwd_sel_e pick(input lc3b_reg src, input ctrl_word_t mc,
                                      input mem_wb_t wb);
        if (mc.load_regfile && !mc.mem_read && mc.dest == src)
            return fwd_mem;
        if (wb.load_regfile && wb.dest == src)
            return fwd_wb;
        return fwd_reg;
    endfunction

    always_comb
    begin
        fwd_sel_a  = pick(ex_ctrl.sr1, mem_ctrl, mem_wb);
        fwd_sel_b  = fwd_reg;
        fwd_sel_st = fwd_reg;
        if (reads_sr2(ex_ctrl) && !ex_ctrl.mem_write)
            fwd_sel_b = pick(ex_ctrl.sr2, mem_ctrl, mem_wb);
        if (ex_ctrl.mem_write)
            fwd_sel_st = pick(ex_ctrl.sr2, mem_ctrl, mem_wb);

        // load in execute feeding the instruction in decode
        stall = ex_ctrl.mem_read &&
                ((reads_sr1(id_ctrl) && ex_ctrl.dest == id_ctrl.sr1) ||
                 (reads_sr2(id_ctrl) && ex_ctrl.dest == id_ctrl.sr2));
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps
`include "lc3b_macros.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic                 stall,
    input  logic                 redirect,
    input  lc3b_pkg::lc3b_word   ir,
    input  lc3b_pkg::lc3b_word   pc_plus2,
    input  lc3b_pkg::mem_wb_t    mem_wb,
    output lc3b_pkg::ctrl_word_t id_ctrl,
    output lc3b_pkg::id_ex_t     id_ex
);
    import lc3b_pkg::*;

    lc3b_word regs [`LC3B_NUM_REGS];
    lc3b_word rf_a;
    lc3b_word rf_b;
    lc3b_word imm5;
    lc3b_word offset;

    always_comb
    begin
        id_ctrl            = '0;
        id_ctrl.opcode     = lc3b_opcode_e'(ir[`LC3B_OPCODE_MSB:`LC3B_OPCODE_LSB]);
        id_ctrl.aluop      = alu_pass;
        id_ctrl.dest       = ir[11:9];
        id_ctrl.sr1        = ir[8:6];
        id_ctrl.sr2        = ir[2:0];
        id_ctrl.nzp_mask   = ir[11:9];
        id_ctrl.imm_enable = ir[5];
        case (id_ctrl.opcode)
            op_add, op_and:
            begin
                id_ctrl.aluop        = (id_ctrl.opcode == op_add) ? alu_add : alu_and;
                id_ctrl.load_regfile = 1'b1;
            end
            op_not:
            begin
                id_ctrl.aluop        = alu_not;
                id_ctrl.imm_enable   = 1'b0;
                id_ctrl.load_regfile = 1'b1;
            end
            op_ldr:
            begin
                id_ctrl.imm_enable   = 1'b0;
                id_ctrl.mem_read     = 1'b1;
                id_ctrl.load_regfile = 1'b1;
            end
            op_str:
            begin
                id_ctrl.imm_enable = 1'b0;
                id_ctrl.mem_write  = 1'b1;
                id_ctrl.sr2        = ir[11:9];
            end
            op_lea:  id_ctrl.load_regfile = 1'b1;
            op_br:   id_ctrl.imm_enable = 1'b0;
            default: id_ctrl = nop_ctrl();      // dropped opcodes
        endcase
        if (ir == '0)
            id_ctrl = nop_ctrl();
    end

    // the write in this step is seen by the read
    assign rf_a = (mem_wb.load_regfile && mem_wb.dest == id_ctrl.sr1) ?
                  mem_wb.value : regs[id_ctrl.sr1];
    assign rf_b = (mem_wb.load_regfile && mem_wb.dest == id_ctrl.sr2) ?
                  mem_wb.value : regs[id_ctrl.sr2];

    assign imm5   = {{11{ir[4]}}, ir[4:0]};
    assign offset = (id_ctrl.mem_read || id_ctrl.mem_write) ?
                    {{9{ir[5]}}, ir[5:0], 1'b0} :       // offset6
                    {{6{ir[8]}}, ir[8:0], 1'b0};        // offset9

    always_ff @(posedge clk)
    begin
        if (advance && mem_wb.load_regfile)
            regs[mem_wb.dest] <= mem_wb.value;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            id_ex <= '{ctrl: nop_ctrl(), default: '0};
        else if (advance)
        begin
            id_ex.ctrl       <= (stall || redirect) ? nop_ctrl() : id_ctrl;
            id_ex.pc_plus2   <= pc_plus2;
            id_ex.src_a      <= rf_a;
            id_ex.src_b      <= id_ctrl.imm_enable ? imm5 : rf_b;
            id_ex.store_data <= rf_b;
            id_ex.offset     <= offset;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps
`include "lc3b_macros.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance,
    input  logic               stall,
    input  logic               redirect,
    input  lc3b_pkg::lc3b_word branch_target,
    input  lc3b_pkg::lc3b_word fetch_word,
    output lc3b_pkg::mem_req_t fetch_req,
    output lc3b_pkg::lc3b_word ir,
    output lc3b_pkg::lc3b_word pc_plus2
);
    import lc3b_pkg::*;

    lc3b_word pc;
    lc3b_word pc_next;

    assign pc_next = pc + lc3b_word'(2);

    // read at the PC in every step
    always_comb
    begin
        fetch_req         = '0;
        fetch_req.read    = 1'b1;
        fetch_req.address = pc;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc       <= `LC3B_RESET_PC;
            pc_plus2 <= `LC3B_RESET_PC;
            ir       <= '0;
        end
        else if (advance)
        begin
            if (redirect)
            begin
                pc <= branch_target;
                ir <= '0;               // squash the word fetched this step
            end
            else if (!stall)
            begin
                pc       <= pc_next;
                pc_plus2 <= pc_next;
                ir       <= fetch_word;
            end
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3b_pkg::mem_req_t fetch_req,
    input  lc3b_pkg::mem_req_t data_req,
    input  lc3b_pkg::lc3b_word mem_rdata,
    input  logic               mem_resp,
    output logic               mem_read,
    output logic               mem_write,
    output lc3b_pkg::lc3b_word mem_address,
    output lc3b_pkg::lc3b_word mem_wdata,
    output lc3b_pkg::lc3b_word fetch_word,
    output lc3b_pkg::lc3b_word data_rdata,
    output logic               advance
);
    import lc3b_pkg::*;

    typedef enum logic [1:0] {st_idle, st_data, st_fetch} arb_state_e;

    arb_state_e state;
    logic       data_done;
    logic       fetch_done;
    mem_req_t   port;

    // data goes first and the port idles when the step is done
    always_comb
    begin
        if ((data_req.read || data_req.write) && !data_done)
            state = st_data;
        else if (fetch_req.read && !fetch_done)
            state = st_fetch;
        else
            state = st_idle;
    end

    always_comb
    begin
        case (state)
            st_data:  port = data_req;
            st_fetch: port = fetch_req;
            default:  port = '0;
        endcase
    end

    assign mem_read    = port.read;
    assign mem_write   = port.write;
    assign mem_address = port.address;
    assign mem_wdata   = port.wdata;
    assign advance     = (state == st_idle);    // lasts one cycle as the flags clear

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            data_done  <= 1'b0;
            fetch_done <= 1'b0;
        end
        else if (advance)
        begin
            data_done  <= 1'b0;
            fetch_done <= 1'b0;
        end
        else if (mem_resp)
        begin
            if (state == st_data)
                data_done <= 1'b1;
            if (state == st_fetch)
                fetch_done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_resp && state == st_data)
            data_rdata <= mem_rdata;
        if (mem_resp && state == st_fetch)
            fetch_word <= mem_rdata;
    end

endmodule

/* rtl/lc3b_pkg.sv */
`include "lc3b_macros.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_lea = 4'b1110
    } lc3b_opcode_e;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} alu_op_e;

    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;

    typedef struct packed {
        lc3b_opcode_e opcode;
        alu_op_e      aluop;
        logic         imm_enable;
        logic         load_regfile;
        logic         mem_read;
        logic         mem_write;
        logic         is_nop;
        lc3b_reg      dest;
        lc3b_reg      sr1;
        lc3b_reg      sr2;          // store source for STR
        lc3b_nzp      nzp_mask;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        lc3b_word   pc_plus2;
        lc3b_word   src_a;
        lc3b_word   src_b;          // register or sext imm5
        lc3b_word   store_data;
        lc3b_word   offset;         // already shifted left by one
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        lc3b_word   result;
        lc3b_word   address;
        lc3b_word   store_data;
        lc3b_word   branch_target;  // also the LEA value
    } ex_mem_t;

    typedef struct packed {
        logic     load_regfile;
        lc3b_reg  dest;
        lc3b_word value;
    } mem_wb_t;

    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word address;
        lc3b_word wdata;
    } mem_req_t;

    // bubble entry for the pipeline registers
    function automatic ctrl_word_t nop_ctrl();
        ctrl_word_t c;
        c = '0;
        c.is_nop = 1'b1;
        return c;
    endfunction

endpackage

/* rtl/lc3b_macros.svh */
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// datapath and register file sizes
`define LC3B_WORD_W 16
`define LC3B_REG_W 3
`define LC3B_NUM_REGS 8

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// opcode field inside the instruction word
`define LC3B_OPCODE_MSB 15
`define LC3B_OPCODE_LSB 12

`endif
